// File: logic/gb_pkg.sv
`default_nettype none

package gb_pkg;

  typedef logic [15:0] addr_t;
  typedef logic [7:0]  byte_t;

  // Bit position in IF and IE, VBlank at 0 up to Joypad at 4
  typedef logic [2:0] irq_index_t;

  typedef enum logic [1:0] {
    T1,
    T2,
    T3,
    T4
  } t_phase_t;

  // Subset opcodes, anything else runs as NOP
  typedef enum logic [7:0] {
    OP_NOP      = 8'h00,
    OP_LD_HL_NN = 8'h21,
    OP_INC_A    = 8'h3C,
    OP_LD_A_N   = 8'h3E,
    OP_LD_HLM_A = 8'h77,
    OP_LD_A_HLM = 8'h7E,
    OP_JP_NN    = 8'hC3,
    OP_ADD_A_N  = 8'hC6,
    OP_LDH_N_A  = 8'hE0,
    OP_LDH_A_N  = 8'hF0,
    OP_DI       = 8'hF3,
    OP_EI       = 8'hFB
  } opcode_t;

  typedef enum logic [1:0] {
    BUS_NONE,
    BUS_READ,
    BUS_WRITE
  } bus_op_t;

  typedef enum logic [2:0] {
    ADDR_PC,
    ADDR_SP,
    ADDR_HL,
    ADDR_FF_N,  // FF00 page plus operand byte
    ADDR_NONE
  } addr_src_t;

  // Work done at T4 of a machine cycle
  typedef enum logic [4:0] {
    UOP_NONE,
    UOP_FETCH,        // Opcode fetch, last cycle of every instruction
    UOP_FETCH_INC_A,
    UOP_FETCH_EI,
    UOP_FETCH_DI,
    UOP_IMM_A,
    UOP_IMM_L,
    UOP_IMM_H,
    UOP_IMM_LO,
    UOP_IMM_HI,
    UOP_ADD_IMM,
    UOP_MEM_A,
    UOP_STORE_A,
    UOP_JUMP,
    UOP_PC_DEC,       // Interrupt entry steps from here on
    UOP_SP_DEC,
    UOP_PUSH_HI,
    UOP_PUSH_LO
  } micro_op_t;

  localparam addr_t IF_ADDR       = 16'hFF0F;
  localparam addr_t IE_ADDR       = 16'hFFFF;
  localparam addr_t DMA_ADDR      = 16'hFF46;
  localparam addr_t OAM_BASE      = 16'hFE00;
  localparam addr_t VECTOR_BASE   = 16'h0040;
  localparam addr_t VECTOR_STRIDE = 16'd8;

  localparam byte_t IF_UNUSED_BITS = 8'hE0;  // IF bits 7..5 always read back as 1

  localparam addr_t RESET_PC = 16'h0100;
  localparam addr_t RESET_SP = 16'hFFFE;

endpackage

`default_nettype wire

// File: logic/gb_cpu_core.sv
`default_nettype none

module gb_cpu_core import gb_pkg::*; (
  input  logic       clk,
  input  logic       reset,
  output addr_t      cpu_addr,
  output byte_t      cpu_wdata,
  output logic       cpu_read,
  output logic       cpu_write,
  input  byte_t      cpu_rdata,
  input  logic       cpu_grant,
  input  logic       irq_pending,
  input  irq_index_t irq_index,
  output logic       irq_ack
);

  addr_t      pc;
  addr_t      sp;
  byte_t      a;
  byte_t      h;
  byte_t      l;
  logic       flag_z;
  logic       flag_c;
  opcode_t    ir;
  byte_t      op_lo;
  byte_t      op_hi;
  byte_t      rdata_q;   // Bus byte taken at T3
  logic       ime;
  t_phase_t   t_phase;
  logic [2:0] mcycle;
  logic       in_isr;    // Running the interrupt entry sequence
  irq_index_t isr_index;

  bus_op_t    bop;
  addr_src_t  asrc;
  micro_op_t  uop;
  logic       last;
  logic       take_irq;
  logic       pc_step;
  logic [8:0] add_sum;
  addr_t      vector_addr;

  // Maps instruction and machine cycle to one micro-step
  function automatic void decode(input opcode_t op, input logic isr, input logic [2:0] mc,
                                 output bus_op_t bus_op, output addr_src_t src,
                                 output micro_op_t step);
    bus_op = BUS_READ;
    src    = ADDR_PC;
    step   = UOP_FETCH;
    if (isr) begin
      case (mc)
        3'd0: begin bus_op = BUS_NONE;  src = ADDR_NONE; step = UOP_PC_DEC;  end
        3'd1: begin bus_op = BUS_NONE;  src = ADDR_NONE; step = UOP_SP_DEC;  end
        3'd2: begin bus_op = BUS_WRITE; src = ADDR_SP;   step = UOP_PUSH_HI; end
        3'd3: begin bus_op = BUS_WRITE; src = ADDR_SP;   step = UOP_PUSH_LO; end
        default: ;  // Fetch at the vector
      endcase
    end else begin
      case (op)
        OP_NOP: ;
        OP_LD_A_N:   if (mc == 3'd0) step = UOP_IMM_A;
        OP_LD_HL_NN: begin
          if (mc == 3'd0) step = UOP_IMM_L;
          if (mc == 3'd1) step = UOP_IMM_H;
        end
        OP_LD_HLM_A: if (mc == 3'd0) begin bus_op = BUS_WRITE; src = ADDR_HL; step = UOP_STORE_A; end
        OP_LD_A_HLM: if (mc == 3'd0) begin src = ADDR_HL; step = UOP_MEM_A; end
        OP_INC_A:    step = UOP_FETCH_INC_A;  // Executes alongside the next fetch
        OP_ADD_A_N:  if (mc == 3'd0) step = UOP_ADD_IMM;
        OP_JP_NN: begin
          if (mc == 3'd0) step = UOP_IMM_LO;
          if (mc == 3'd1) step = UOP_IMM_HI;
          if (mc == 3'd2) begin bus_op = BUS_NONE; src = ADDR_NONE; step = UOP_JUMP; end
        end
        OP_LDH_N_A: begin
          if (mc == 3'd0) step = UOP_IMM_LO;
          if (mc == 3'd1) begin bus_op = BUS_WRITE; src = ADDR_FF_N; step = UOP_STORE_A; end
        end
        OP_LDH_A_N: begin
          if (mc == 3'd0) step = UOP_IMM_LO;
          if (mc == 3'd1) begin src = ADDR_FF_N; step = UOP_MEM_A; end
        end
        OP_EI: step = UOP_FETCH_EI;
        OP_DI: step = UOP_FETCH_DI;
        default: ;
      endcase
    end
  endfunction

  always_comb begin
    decode(ir, in_isr, mcycle, bop, asrc, uop);
  end

  assign last    = uop inside {UOP_FETCH, UOP_FETCH_INC_A, UOP_FETCH_EI, UOP_FETCH_DI};
  assign pc_step = last || (uop inside {UOP_IMM_A, UOP_IMM_L, UOP_IMM_H, UOP_IMM_LO,
                                        UOP_IMM_HI, UOP_ADD_IMM});

  // DI masks the check in its own cycle
  assign take_irq    = last && ime && (uop != UOP_FETCH_DI) && irq_pending;
  assign irq_ack     = cpu_grant && (t_phase == T4) && take_irq;
  assign add_sum     = {1'b0, a} + {1'b0, rdata_q};
  assign vector_addr = VECTOR_BASE + VECTOR_STRIDE * addr_t'(isr_index);

  always_comb begin
    case (asrc)
      ADDR_PC:   cpu_addr = pc;
      ADDR_SP:   cpu_addr = sp;
      ADDR_HL:   cpu_addr = {h, l};
      ADDR_FF_N: cpu_addr = {8'hFF, op_lo};
      default:   cpu_addr = '0;
    endcase
  end

  always_comb begin
    case (uop)
      UOP_PUSH_HI: cpu_wdata = pc[15:8];
      UOP_PUSH_LO: cpu_wdata = pc[7:0];
      default:     cpu_wdata = a;
    endcase
  end

  // Strobes span T2 and T3 only
  assign cpu_read  = (bop == BUS_READ)  && (t_phase inside {T2, T3});
  assign cpu_write = (bop == BUS_WRITE) && (t_phase inside {T2, T3});

  always_ff @(posedge clk) begin
    if (cpu_grant && t_phase == T3 && bop == BUS_READ) rdata_q <= cpu_rdata;
    if (cpu_grant && t_phase == T4) begin
      if (uop == UOP_IMM_LO) op_lo <= rdata_q;
      if (uop == UOP_IMM_HI) op_hi <= rdata_q;
    end
  end

  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      pc        <= RESET_PC;
      sp        <= RESET_SP;
      a         <= '0;
      h         <= '0;
      l         <= '0;
      flag_z    <= 1'b0;
      flag_c    <= 1'b0;
      ir        <= OP_NOP;  // First step is then the fetch at RESET_PC
      ime       <= 1'b0;
      t_phase   <= T1;
      mcycle    <= '0;
      in_isr    <= 1'b0;
      isr_index <= '0;
    end else if (cpu_grant) begin  // Frozen while DMA owns the bus
      case (t_phase)
        T1: t_phase <= T2;
        T2: t_phase <= T3;
        T3: t_phase <= T4;
        T4: begin
          t_phase <= T1;
          if (pc_step) pc <= pc + 16'd1;
          case (uop)
            UOP_FETCH_INC_A: begin
              a      <= a + 8'd1;
              flag_z <= (a == 8'hFF);
            end
            UOP_FETCH_EI: ime <= 1'b1;
            UOP_FETCH_DI: ime <= 1'b0;
            UOP_IMM_A,
            UOP_MEM_A:    a <= rdata_q;
            UOP_IMM_L:    l <= rdata_q;
            UOP_IMM_H:    h <= rdata_q;
            UOP_ADD_IMM: begin
              {flag_c, a} <= add_sum;
              flag_z      <= (add_sum[7:0] == 8'h00);
            end
            UOP_JUMP:    pc <= {op_hi, op_lo};
            UOP_PC_DEC:  pc <= pc - 16'd1;  // Undo the fetch of the dropped opcode
            UOP_SP_DEC,
            UOP_PUSH_HI: sp <= sp - 16'd1;
            UOP_PUSH_LO: pc <= vector_addr;
            default: ;
          endcase
          if (last) begin
            mcycle <= '0;
            if (take_irq) begin
              in_isr    <= 1'b1;
              ime       <= 1'b0;
              isr_index <= irq_index;
            end else begin
              in_isr <= 1'b0;
              ir     <= opcode_t'(rdata_q);
            end
          end else begin
            mcycle <= mcycle + 3'd1;
          end
        end
        default: t_phase <= T1;
      endcase
    end
  end

endmodule

`default_nettype wire

// File: logic/gb_interrupt_ctrl.sv
`default_nettype none

module gb_interrupt_ctrl import gb_pkg::*; (
  input  logic       clk,
  input  logic       reset,
  input  logic       io_read,
  input  logic       io_write,
  input  addr_t      io_addr,
  input  byte_t      io_wdata,
  output byte_t      io_rdata,
  input  logic [4:0] irq_req,
  input  logic       irq_ack,
  output logic       irq_pending,
  output irq_index_t irq_index
);

  logic [4:0] if_q;  // Only the five request bits are stored
  logic [4:0] if_next;
  byte_t      ie_q;
  logic [4:0] pending;

  always_comb begin
    if_next = if_q;
    if (io_write && io_addr == IF_ADDR) if_next = io_wdata[4:0];
    if (irq_ack) if_next[irq_index] = 1'b0;
    // New requests override a clear of the same bit
    if_next = if_next | irq_req;
  end

  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      if_q <= '0;
      ie_q <= '0;
    end else begin
      if_q <= if_next;
      if (io_write && io_addr == IE_ADDR) ie_q <= io_wdata;
    end
  end

  always_comb begin
    io_rdata = '0;
    if (io_read) begin
      if (io_addr == IF_ADDR) begin
        io_rdata = IF_UNUSED_BITS | {3'b000, if_q};
      end else if (io_addr == IE_ADDR) begin
        io_rdata = ie_q;
      end
    end
  end

  assign pending     = if_q & ie_q[4:0];
  assign irq_pending = |pending;

  // Lowest set bit wins, VBlank first
  always_comb begin
    irq_index = '0;
    for (int i = 4; i >= 0; i--) begin
      if (pending[i]) irq_index = irq_index_t'(i);
    end
  end

endmodule

`default_nettype wire

// File: logic/gb_oam_dma.sv
`default_nettype none

module gb_oam_dma import gb_pkg::*; #(
  parameter int DMA_LENGTH = 160
) (
  input  logic  clk,
  input  logic  reset,
  input  logic  dma_start,
  input  byte_t dma_page,
  output addr_t dma_addr,
  output byte_t dma_wdata,
  output logic  dma_read,
  output logic  dma_write,
  input  byte_t dma_rdata,
  output logic  dma_busy
);

  localparam int CNT_W = (DMA_LENGTH > 1) ? $clog2(DMA_LENGTH) : 1;

  typedef enum logic [1:0] {
    DMA_IDLE,
    DMA_READ,
    DMA_WRITE
  } dma_state_t;

  dma_state_t       state;
  logic [CNT_W-1:0] index;
  byte_t            src_page;
  byte_t            data_q;   // Byte in flight between read and write
  logic             start_q;  // Previous dma_start, the strobe spans two clocks

  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      state   <= DMA_IDLE;
      index   <= '0;
      start_q <= 1'b0;
    end else begin
      start_q <= dma_start;
      case (state)
        DMA_IDLE: begin
          if (dma_start && !start_q) begin
            state <= DMA_READ;
            index <= '0;
          end
        end
        DMA_READ: state <= DMA_WRITE;
        DMA_WRITE: begin
          if (index == CNT_W'(DMA_LENGTH - 1)) begin
            state <= DMA_IDLE;
          end else begin
            index <= index + 1'b1;
            state <= DMA_READ;
          end
        end
        default: state <= DMA_IDLE;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (state == DMA_IDLE && dma_start) src_page <= dma_page;
    if (state == DMA_READ) data_q <= dma_rdata;
  end

  assign dma_busy  = (state != DMA_IDLE);
  assign dma_read  = (state == DMA_READ);
  assign dma_write = (state == DMA_WRITE);
  assign dma_wdata = data_q;
  assign dma_addr  = (state == DMA_WRITE) ? OAM_BASE + addr_t'(index)
                                          : {src_page, byte_t'(index)};

endmodule

`default_nettype wire

// File: logic/gb_bus_arbiter.sv
`default_nettype none

module gb_bus_arbiter import gb_pkg::*; (
  input  addr_t cpu_addr,
  input  byte_t cpu_wdata,
  input  logic  cpu_read,
  input  logic  cpu_write,
  output byte_t cpu_rdata,
  output logic  cpu_grant,
  input  addr_t dma_addr,
  input  byte_t dma_wdata,
  input  logic  dma_read,
  input  logic  dma_write,
  output byte_t dma_rdata,
  input  logic  dma_busy,
  output addr_t mem_addr,
  output byte_t mem_wdata,
  output logic  mem_read,
  output logic  mem_write,
  input  byte_t mem_rdata,
  output logic  io_read,
  output logic  io_write,
  output addr_t io_addr,
  output byte_t io_wdata,
  input  byte_t io_rdata,
  output logic  dma_start,
  output byte_t dma_page
);

  logic cpu_io;   // IF or IE
  logic cpu_dma;  // DMA start register

  assign cpu_grant = !dma_busy;
  assign cpu_io    = (cpu_addr == IF_ADDR) || (cpu_addr == IE_ADDR);
  assign cpu_dma   = (cpu_addr == DMA_ADDR);

  // No register access while the CPU is stalled mid cycle
  assign io_read  = cpu_grant && cpu_read && cpu_io;
  assign io_write = cpu_grant && cpu_write && cpu_io;
  assign io_addr  = cpu_addr;
  assign io_wdata = cpu_wdata;

  // Left open during a stall so the engine sees one edge per write
  assign dma_start = cpu_write && cpu_dma;
  assign dma_page  = cpu_wdata;

  always_comb begin
    if (dma_busy) begin
      mem_addr  = dma_addr;
      mem_wdata = dma_wdata;
      mem_read  = dma_read;
      mem_write = dma_write;
    end else begin
      mem_addr  = cpu_addr;
      mem_wdata = cpu_wdata;
      mem_read  = cpu_read && !cpu_io;
      mem_write = cpu_write && !cpu_io && !cpu_dma;
    end
  end

  assign cpu_rdata = cpu_io ? io_rdata : mem_rdata;
  assign dma_rdata = mem_rdata;

endmodule

`default_nettype wire

// File: logic/gb_soc.sv
`default_nettype none

module gb_soc import gb_pkg::*; #(
  parameter int DMA_LENGTH = 160
) (
  input  logic       clk,
  input  logic       reset,
  input  logic [4:0] irq_req,
  output addr_t      mem_addr,
  output byte_t      mem_wdata,
  output logic       mem_read,
  output logic       mem_write,
  input  byte_t      mem_rdata
);

  // CPU side
  addr_t      cpu_addr;
  byte_t      cpu_wdata;
  byte_t      cpu_rdata;
  logic       cpu_read;
  logic       cpu_write;
  logic       cpu_grant;

  // DMA side
  addr_t      dma_addr;
  byte_t      dma_wdata;
  byte_t      dma_rdata;
  logic       dma_read;
  logic       dma_write;
  logic       dma_busy;
  logic       dma_start;
  byte_t      dma_page;

  // Interrupt register access and request path
  logic       io_read;
  logic       io_write;
  addr_t      io_addr;
  byte_t      io_wdata;
  byte_t      io_rdata;
  logic       irq_pending;
  logic       irq_ack;
  irq_index_t irq_index;

  gb_cpu_core u_cpu (
    .clk, .reset,
    .cpu_addr, .cpu_wdata, .cpu_read, .cpu_write, .cpu_rdata, .cpu_grant,
    .irq_pending, .irq_index, .irq_ack
  );

  gb_bus_arbiter u_arbiter (
    .cpu_addr, .cpu_wdata, .cpu_read, .cpu_write, .cpu_rdata, .cpu_grant,
    .dma_addr, .dma_wdata, .dma_read, .dma_write, .dma_rdata, .dma_busy,
    .mem_addr, .mem_wdata, .mem_read, .mem_write, .mem_rdata,
    .io_read, .io_write, .io_addr, .io_wdata, .io_rdata,
    .dma_start, .dma_page
  );

  gb_interrupt_ctrl u_irq (
    .clk, .reset,
    .io_read, .io_write, .io_addr, .io_wdata, .io_rdata,
    .irq_req, .irq_ack, .irq_pending, .irq_index
  );

  gb_oam_dma #(.DMA_LENGTH(DMA_LENGTH)) u_dma (
    .clk, .reset,
    .dma_start, .dma_page,
    .dma_addr, .dma_wdata, .dma_read, .dma_write, .dma_rdata, .dma_busy
  );

endmodule

`default_nettype wire

// File: tests/tb_gb_soc.sv
`default_nettype none

module tb_gb_soc import gb_pkg::*; ();

  localparam int DMA_LEN         = 8;
  localparam int N_EXP           = 12 + DMA_LEN;
  localparam int IRQ_TRIGGER     = 6 + DMA_LEN;   // Writes seen before the request pulse
  localparam int WATCHDOG_CLOCKS = N_EXP * 16 + DMA_LEN * 2 + 200;

  localparam byte_t IMM_A1      = 8'h5A;
  localparam byte_t IMM_ADD1    = 8'h27;
  localparam byte_t IMM_A2      = 8'hC8;
  localparam byte_t IMM_ADD2    = 8'h5B;  // Carries out of bit 7
  localparam byte_t IE_VAL      = 8'h05;  // VBlank and Timer enabled
  localparam byte_t IF_VAL      = 8'h0A;
  localparam byte_t DMA_PAGE    = 8'hC0;
  localparam byte_t MARK_DMA    = 8'h5C;
  localparam byte_t MARK_EI     = 8'h33;
  localparam byte_t MARK_VBLANK = 8'h11;
  localparam byte_t MARK_TIMER  = 8'h22;

  localparam addr_t STORE_ADDR = 16'hC100;
  localparam addr_t LOOP_ADDR  = 16'h0127;  // JP to itself at the end of the main code
  localparam addr_t TIMER_LOOP = 16'h0053;
  localparam addr_t VBLANK_VEC = VECTOR_BASE;
  localparam addr_t TIMER_VEC  = VECTOR_BASE + VECTOR_STRIDE * 16'd2;

  logic       clk;
  logic       reset;
  logic [4:0] irq_req;
  addr_t      mem_addr;
  byte_t      mem_wdata;
  logic       mem_read;
  logic       mem_write;
  byte_t      mem_rdata;

  byte_t       mem [0:65535];
  addr_t       exp_addr [0:N_EXP-1];
  byte_t       exp_data [0:N_EXP-1];
  byte_t       dma_bytes [0:DMA_LEN-1];
  int          exp_count;
  int          wr_count;
  logic        write_q;
  logic [31:0] lfsr;

  // Main code at RESET_PC
  byte_t main_code [0:41] = '{
    OP_LD_HL_NN, STORE_ADDR[7:0], STORE_ADDR[15:8],
    OP_LD_A_N, IMM_A1, OP_ADD_A_N, IMM_ADD1, OP_INC_A, OP_LD_HLM_A,
    OP_LD_A_N, IMM_A2, OP_ADD_A_N, IMM_ADD2, OP_LD_HLM_A,
    OP_LD_A_N, IE_VAL, OP_LDH_N_A, IE_ADDR[7:0],
    OP_LD_A_N, IF_VAL, OP_LDH_N_A, IF_ADDR[7:0],
    OP_LDH_A_N, IE_ADDR[7:0], OP_LD_HLM_A,
    OP_LDH_A_N, IF_ADDR[7:0], OP_LD_HLM_A,
    OP_LD_A_N, DMA_PAGE, OP_LDH_N_A, DMA_ADDR[7:0],
    OP_LD_A_N, MARK_DMA, OP_LD_HLM_A,
    OP_EI, OP_LD_A_N, MARK_EI, OP_LD_HLM_A,
    OP_JP_NN, LOOP_ADDR[7:0], LOOP_ADDR[15:8]
  };

  byte_t vblank_code [0:6] = '{
    OP_LD_A_N, MARK_VBLANK, OP_LD_HLM_A, OP_EI,
    OP_JP_NN, LOOP_ADDR[7:0], LOOP_ADDR[15:8]
  };

  byte_t timer_code [0:5] = '{
    OP_LD_A_N, MARK_TIMER, OP_LD_HLM_A,
    OP_JP_NN, TIMER_LOOP[7:0], TIMER_LOOP[15:8]
  };

  gb_soc #(.DMA_LENGTH(DMA_LEN)) DUT (
    .clk, .reset, .irq_req,
    .mem_addr, .mem_wdata, .mem_read, .mem_write, .mem_rdata
  );

  always #4 clk = ~clk;

  assign mem_rdata = mem[mem_addr];  // Combinational memory

  always @(posedge clk) begin
    if (mem_write) mem[mem_addr] <= mem_wdata;
  end

  function automatic logic [31:0] lfsr_next(input logic [31:0] state);
    if (state[0]) lfsr_next = (state >> 1) ^ 32'h8020_0003;
    else lfsr_next = state >> 1;
  endfunction

  // One LFSR step per bit
  task automatic random_byte(output byte_t value);
    value = '0;
    for (int b = 0; b < 8; b++) begin
      value = {value[6:0], lfsr[0]};
      lfsr  = lfsr_next(lfsr);
    end
  endtask

  task automatic add_expected(input addr_t addr, input byte_t data);
    exp_addr[exp_count] = addr;
    exp_data[exp_count] = data;
    exp_count++;
  endtask

  task automatic abort_run(input string reason);
    $display("%s", reason);
    $display(">>> FAIL");
    $fatal(1);
  endtask

  task automatic check_addr(input string name, input addr_t got, input addr_t expected);
    if (got !== expected)
      abort_run($sformatf("FAIL %0t %s: got %h, expected %h", $time, name, got, expected));
  endtask

  task automatic check_byte(input string name, input byte_t got, input byte_t expected);
    if (got !== expected)
      abort_run($sformatf("FAIL %0t %s: got %h, expected %h", $time, name, got, expected));
  endtask

  task automatic check_bit(input string name, input logic got, input logic expected);
    if (got !== expected)
      abort_run($sformatf("FAIL %0t %s: got %b, expected %b", $time, name, got, expected));
  endtask

  initial begin
    byte_t value;
    clk       = 1'b0;
    reset     = 1'b1;
    irq_req   = '0;
    exp_count = 0;
    wr_count  = 0;
    write_q   = 1'b0;
    lfsr      = 32'h42e1_413f;
    for (int i = 0; i < 65536; i++) mem[i] = 8'h00;
    for (int i = 0; i < 42; i++) mem[RESET_PC + addr_t'(i)] = main_code[i];
    for (int i = 0; i < 7; i++) mem[VBLANK_VEC + addr_t'(i)] = vblank_code[i];
    for (int i = 0; i < 6; i++) mem[TIMER_VEC + addr_t'(i)] = timer_code[i];
    for (int i = 0; i < 256; i++) begin
      random_byte(value);
      mem[{DMA_PAGE, 8'(i)}] = value;
      if (i < DMA_LEN) dma_bytes[i] = value;
    end

    // Writes in program order
    add_expected(STORE_ADDR, 8'(IMM_A1 + IMM_ADD1 + 8'd1));
    add_expected(STORE_ADDR, 8'(IMM_A2 + IMM_ADD2));
    add_expected(STORE_ADDR, IE_VAL);
    add_expected(STORE_ADDR, IF_VAL | 8'hE0);
    for (int i = 0; i < DMA_LEN; i++) add_expected(OAM_BASE + addr_t'(i), dma_bytes[i]);
    add_expected(STORE_ADDR, MARK_DMA);
    add_expected(STORE_ADDR, MARK_EI);
    add_expected(RESET_SP - 16'd1, LOOP_ADDR[15:8]);  // VBlank entry
    add_expected(RESET_SP - 16'd2, LOOP_ADDR[7:0]);
    add_expected(STORE_ADDR, MARK_VBLANK);
    add_expected(RESET_SP - 16'd3, LOOP_ADDR[15:8]);  // Timer entry
    add_expected(RESET_SP - 16'd4, LOOP_ADDR[7:0]);
    add_expected(STORE_ADDR, MARK_TIMER);

    repeat (2) @(posedge clk);
    reset <= 1'b0;
    wait (wr_count == N_EXP);
    $display(">>> PASS");
    $finish;
  end

  // Bus stays quiet through reset and the first T1
  initial begin
    @(negedge clk);
    while (reset) begin
      check_bit("mem_read", mem_read, 1'b0);
      check_bit("mem_write", mem_write, 1'b0);
      @(negedge clk);
    end
    check_bit("mem_read", mem_read, 1'b0);
    check_bit("mem_write", mem_write, 1'b0);
    @(negedge clk);
    while (!mem_read) @(negedge clk);
    check_addr("mem_addr", mem_addr, RESET_PC);
  end

  // VBlank and Timer requested together once the EI marker is out
  initial begin
    wait (wr_count == IRQ_TRIGGER);
    @(posedge clk);
    irq_req <= 5'b00101;
    @(posedge clk);
    irq_req <= '0;
  end

  // One table entry per write strobe pulse
  always @(negedge clk) begin
    if (!reset) begin
      if (mem_write && !write_q && wr_count < N_EXP) begin
        check_addr("mem_addr", mem_addr, exp_addr[wr_count]);
        check_byte("mem_wdata", mem_wdata, exp_data[wr_count]);
        wr_count = wr_count + 1;
      end
      write_q = mem_write;
    end
  end

  initial begin
    repeat (WATCHDOG_CLOCKS) @(posedge clk);
    abort_run($sformatf("Timeout: only %0d of %0d expected memory writes appeared",
                        wr_count, N_EXP));
  end

endmodule

`default_nettype wire

// File: project.f
logic/gb_pkg.sv
logic/gb_cpu_core.sv
logic/gb_interrupt_ctrl.sv
logic/gb_oam_dma.sv
logic/gb_bus_arbiter.sv
logic/gb_soc.sv
tests/tb_gb_soc.sv

// File: Bender.yml
package:
  name: gb_soc

sources:
  - logic/gb_pkg.sv
  - logic/gb_cpu_core.sv
  - logic/gb_interrupt_ctrl.sv
  - logic/gb_oam_dma.sv
  - logic/gb_bus_arbiter.sv
  - logic/gb_soc.sv
  - target: test
    files:
      - tests/tb_gb_soc.sv
